// ==== hdl/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Word width of registers, PC and instruction
`define DATA_WIDTH 32

// Register index width, 32 architectural registers
`define REG_ADDR_WIDTH 5

// First fetch address after reset
`define RESET_PC 32'h8000_0000

// Instruction memory size in words
`define IMEM_DEPTH 64
`define IMEM_ADDR_WIDTH $clog2(`IMEM_DEPTH)

`endif

// ==== hdl/cpu_pkg.sv ====
`include "cpu_params.svh"

package cpu_pkg;

    // Command handed from decode to execute
    typedef enum logic [1:0] {
        cmd_none = 2'd0,
        cmd_add  = 2'd1,
        cmd_halt = 2'd2
    } exu_cmd_e;

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                imm12;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]                imm20;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } u_fmt_t;

    // One instruction word seen through each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } inst_u;

endpackage

// ==== hdl/ifu.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module ifu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        halt_req,
    input  logic                        imem_we,
    input  logic [`IMEM_ADDR_WIDTH-1:0] imem_addr,
    input  logic [`DATA_WIDTH-1:0]      imem_wdata,
    output logic [`DATA_WIDTH-1:0]      pc,
    output logic [`DATA_WIDTH-1:0]      inst,
    output logic                        halted
);

    localparam logic [`DATA_WIDTH-1:0] pc_step = 4;

    logic [`DATA_WIDTH-1:0]      imem [0:`IMEM_DEPTH-1];
    logic [`DATA_WIDTH-1:0]      pc_offset;
    logic [`IMEM_ADDR_WIDTH-1:0] word_idx;

    // Word index relative to the reset PC, wraps at the memory depth
    assign pc_offset = pc - `RESET_PC;
    assign word_idx  = pc_offset[`IMEM_ADDR_WIDTH+1:2];
    assign inst      = imem[word_idx];

    // Load port from the testbench
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= `RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            if (halt_req) begin
                // PC stays on the ebreak
                halted <= 1'b1;
            end else begin
                pc <= pc + pc_step;
            end
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    );

    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted
    );

endmodule

// ==== hdl/idu.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module idu
    import cpu_pkg::*;
(
    input  logic [`DATA_WIDTH-1:0]     inst,
    input  logic [`DATA_WIDTH-1:0]     pc,
    input  logic [`DATA_WIDTH-1:0]     rdata1,
    input  logic [`DATA_WIDTH-1:0]     rdata2,
    output logic [`REG_ADDR_WIDTH-1:0] raddr1,
    output logic [`REG_ADDR_WIDTH-1:0] raddr2,
    output logic [`REG_ADDR_WIDTH-1:0] rd,
    output logic [`DATA_WIDTH-1:0]     src1,
    output logic [`DATA_WIDTH-1:0]     src2,
    output exu_cmd_e                   cmd
);

    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [2:0] f3_add   = 3'b000;
    localparam logic [6:0] f7_add   = 7'b0000000;

    localparam logic [`DATA_WIDTH-1:0] inst_ebreak = 32'h0010_0073;

    inst_u                  dec;
    logic [`DATA_WIDTH-1:0] imm_i;
    logic [`DATA_WIDTH-1:0] imm_u;

    assign dec = inst;

    // Sign-extended I immediate and the full U immediate
    assign imm_i = {{(`DATA_WIDTH-12){dec.i_fmt.imm12[11]}}, dec.i_fmt.imm12};
    assign imm_u = {dec.u_fmt.imm20, 12'b0};

    always_comb begin
        raddr1 = '0;
        raddr2 = '0;
        rd     = '0;
        src1   = '0;
        src2   = '0;
        cmd    = cmd_none;

        if (inst == inst_ebreak) begin
            cmd = cmd_halt;
        end else begin
            case (dec.r_fmt.opcode)
                op_imm: begin
                    // addi only
                    if (dec.i_fmt.funct3 == f3_add) begin
                        raddr1 = dec.i_fmt.rs1;
                        rd     = dec.i_fmt.rd;
                        src1   = imm_i;
                        src2   = rdata1;
                        cmd    = cmd_add;
                    end
                end
                op_auipc: begin
                    rd   = dec.u_fmt.rd;
                    src1 = pc;
                    src2 = imm_u;
                    cmd  = cmd_add;
                end
                op_reg: begin
                    if (dec.r_fmt.funct7 == f7_add && dec.r_fmt.funct3 == f3_add) begin
                        raddr1 = dec.r_fmt.rs1;
                        raddr2 = dec.r_fmt.rs2;
                        rd     = dec.r_fmt.rd;
                        src1   = rdata1;
                        src2   = rdata2;
                        cmd    = cmd_add;
                    end
                end
                default: begin
                    // Unknown encodings retire as no-ops
                    cmd = cmd_none;
                end
            endcase
        end

        a_none_no_rd: assert (cmd != cmd_none || rd == '0);
    end

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module regfile (
    input  logic                       clk,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2,
    input  logic                       wb_en,
    input  logic [`REG_ADDR_WIDTH-1:0] wb_addr,
    input  logic [`DATA_WIDTH-1:0]     wb_data,
    output logic [`DATA_WIDTH-1:0]     rdata1,
    output logic [`DATA_WIDTH-1:0]     rdata2
);

    localparam int num_regs = 1 << `REG_ADDR_WIDTH;

    logic [`DATA_WIDTH-1:0] regs [0:num_regs-1];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Index zero reads as zero whatever the array holds
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== hdl/exu.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module exu
    import cpu_pkg::*;
(
    input  exu_cmd_e                   cmd,
    input  logic [`DATA_WIDTH-1:0]     src1,
    input  logic [`DATA_WIDTH-1:0]     src2,
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic                       halted,
    output logic                       wb_en,
    output logic [`REG_ADDR_WIDTH-1:0] wb_addr,
    output logic [`DATA_WIDTH-1:0]     wb_data,
    output logic                       halt_req
);

    always_comb begin
        wb_en    = 1'b0;
        wb_addr  = rd;
        wb_data  = '0;
        halt_req = 1'b0;

        case (cmd)
            cmd_add: begin
                wb_data = src1 + src2;
                // No write-back once the core has stopped
                wb_en   = (rd != '0) && !halted;
            end
            cmd_halt: begin
                halt_req = 1'b1;
            end
            default: begin
                wb_en = 1'b0;
            end
        endcase

        a_wb_or_halt: assert (!(wb_en && halt_req));
    end

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        imem_we,
    input  logic [`IMEM_ADDR_WIDTH-1:0] imem_addr,
    input  logic [`DATA_WIDTH-1:0]      imem_wdata,
    output logic [`DATA_WIDTH-1:0]      commit_pc,
    output logic                        commit_wb_en,
    output logic [`REG_ADDR_WIDTH-1:0]  commit_wb_addr,
    output logic [`DATA_WIDTH-1:0]      commit_wb_data,
    output logic                        halted
);

    logic [`DATA_WIDTH-1:0]     inst;
    logic [`REG_ADDR_WIDTH-1:0] raddr1;
    logic [`REG_ADDR_WIDTH-1:0] raddr2;
    logic [`DATA_WIDTH-1:0]     rdata1;
    logic [`DATA_WIDTH-1:0]     rdata2;
    logic [`DATA_WIDTH-1:0]     src1;
    logic [`DATA_WIDTH-1:0]     src2;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    exu_cmd_e                   cmd;
    logic                       halt_req;

    // Commit ports double as the internal PC and write-back nets
    ifu ifu0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .halt_req   (halt_req),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .pc         (commit_pc),
        .inst       (inst),
        .halted     (halted)
    );

    idu idu0 (
        .inst   (inst),
        .pc     (commit_pc),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rd     (rd),
        .src1   (src1),
        .src2   (src2),
        .cmd    (cmd)
    );

    regfile regfile0 (
        .clk     (clk),
        .raddr1  (raddr1),
        .raddr2  (raddr2),
        .wb_en   (commit_wb_en),
        .wb_addr (commit_wb_addr),
        .wb_data (commit_wb_data),
        .rdata1  (rdata1),
        .rdata2  (rdata2)
    );

    exu exu0 (
        .cmd      (cmd),
        .src1     (src1),
        .src2     (src2),
        .rd       (rd),
        .halted   (halted),
        .wb_en    (commit_wb_en),
        .wb_addr  (commit_wb_addr),
        .wb_data  (commit_wb_data),
        .halt_req (halt_req)
    );

endmodule

// ==== bench/cpu_tb.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_tb;

    logic                        clk;
    logic                        rst_n;
    logic                        imem_we;
    logic [`IMEM_ADDR_WIDTH-1:0] imem_addr;
    logic [`DATA_WIDTH-1:0]      imem_wdata;
    logic [`DATA_WIDTH-1:0]      commit_pc;
    logic                        commit_wb_en;
    logic [`REG_ADDR_WIDTH-1:0]  commit_wb_addr;
    logic [`DATA_WIDTH-1:0]      commit_wb_data;
    logic                        halted;

    // Program of the current test and the reference model state
    logic [31:0] prog [$];
    logic [31:0] model_regs [0:31];
    logic [31:0] model_pc;
    int          cycle_cnt = 0;
    int          budget = 0;
    int          seed_dummy;

    cpu_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .imem_we        (imem_we),
        .imem_addr      (imem_addr),
        .imem_wdata     (imem_wdata),
        .commit_pc      (commit_pc),
        .commit_wb_en   (commit_wb_en),
        .commit_wb_addr (commit_wb_addr),
        .commit_wb_data (commit_wb_data),
        .halted         (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > budget + 50) begin
            $display("Timeout: the tests did not finish within %0d cycles", budget + 50);
            $display("=== FAIL ===");
            $fatal(1, "watchdog expired");
        end
    end

    function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_auipc(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0010111};
    endfunction

    function automatic logic [31:0] encode_add(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    // Expected retirement of one word from the architectural rules
    function automatic void predict(input logic [31:0] w, output logic en,
                                    output logic [4:0] rd, output logic [31:0] data,
                                    output logic halt);
        en   = 1'b0;
        rd   = w[11:7];
        data = '0;
        halt = 1'b0;
        if (w == 32'h0010_0073) begin
            halt = 1'b1;
        end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
            en   = 1'b1;
            data = {{20{w[31]}}, w[31:20]} + model_regs[w[19:15]];
        end else if (w[6:0] == 7'b0010111) begin
            en   = 1'b1;
            data = model_pc + {w[31:12], 12'b0};
        end else if (w[6:0] == 7'b0110011 && w[14:12] == 3'b000 && w[31:25] == 7'b0) begin
            en   = 1'b1;
            data = model_regs[w[19:15]] + model_regs[w[24:20]];
        end
        if (rd == 5'd0) begin
            en = 1'b0;
        end
    endfunction

    task automatic check_value(input string field, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, field, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "commit port mismatch");
        end
    endtask

    // Load under reset, release it, then follow commits until ebreak and hold
    task automatic run_program(input int hold);
        int          i;
        int          idx;
        int          reset_len;
        logic        exp_en;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic        exp_halt;
        logic [31:0] halt_pc;

        reset_len = (prog.size() > 8) ? prog.size() : 8;
        budget += reset_len + prog.size() + hold + 4;
        @(posedge clk);
        rst_n <= 1'b0;
        for (i = 0; i < reset_len; i++) begin
            if (i < prog.size()) begin
                imem_we    <= 1'b1;
                imem_addr  <= i[`IMEM_ADDR_WIDTH-1:0];
                imem_wdata <= prog[i];
            end else begin
                imem_we <= 1'b0;
            end
            @(posedge clk);
        end
        imem_we <= 1'b0;
        rst_n   <= 1'b1;

        model_pc = `RESET_PC;
        exp_halt = 1'b0;
        while (!exp_halt) begin
            @(negedge clk);
            idx = int'((model_pc - `RESET_PC) >> 2) % `IMEM_DEPTH;
            predict(prog[idx], exp_en, exp_rd, exp_data, exp_halt);
            check_value("halted", {31'b0, halted}, 32'd0);
            check_value("commit_pc", commit_pc, model_pc);
            check_value("commit_wb_en", {31'b0, commit_wb_en}, {31'b0, exp_en});
            if (exp_en) begin
                check_value("commit_wb_addr", {27'b0, commit_wb_addr}, {27'b0, exp_rd});
                check_value("commit_wb_data", commit_wb_data, exp_data);
                model_regs[exp_rd] = exp_data;
            end
            if (!exp_halt) begin
                model_pc = model_pc + 32'd4;
            end
        end

        halt_pc = model_pc;
        for (i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("halted", {31'b0, halted}, 32'd1);
            check_value("commit_pc", commit_pc, halt_pc);
            check_value("commit_wb_en", {31'b0, commit_wb_en}, 32'd0);
        end
    endtask

    task automatic test_addi_chain();
        int         k;
        logic [11:0] imm;
        logic [4:0]  rd;

        prog.delete();
        for (k = 1; k <= 5; k++) begin
            prog.push_back(encode_addi(5'(k), 5'd0, 12'($urandom)));
        end
        for (k = 0; k < 10; k++) begin
            imm     = 12'($urandom);
            // Every other immediate is negative
            imm[11] = k[0];
            rd      = (k == 4) ? 5'd0 : 5'(1 + $urandom % 5);
            prog.push_back(encode_addi(rd, 5'(1 + $urandom % 5), imm));
        end
        prog.push_back(32'h0010_0073);
        run_program(1);
    endtask

    task automatic test_auipc();
        int k;

        prog.delete();
        for (k = 1; k <= 6; k++) begin
            prog.push_back(encode_auipc(5'(k + 8), 20'($urandom)));
        end
        prog.push_back(32'h0010_0073);
        run_program(1);
    endtask

    task automatic test_add_two_sources();
        int k;

        prog.delete();
        for (k = 1; k <= 4; k++) begin
            prog.push_back(encode_addi(5'(k), 5'd0, 12'($urandom)));
        end
        // Each add reads the result of the one before it
        prog.push_back(encode_add(5'd5, 5'd1, 5'd2));
        prog.push_back(encode_add(5'd6, 5'd5, 5'd3));
        prog.push_back(encode_add(5'd7, 5'd6, 5'd6));
        prog.push_back(encode_add(5'd8, 5'd4, 5'd7));
        prog.push_back(encode_add(5'd0, 5'd1, 5'd2));
        prog.push_back(32'h0010_0073);
        run_program(1);
    endtask

    task automatic test_unknown_encodings();
        prog.delete();
        prog.push_back(encode_addi(5'd1, 5'd0, 12'h155));
        prog.push_back(encode_addi(5'd2, 5'd0, 12'h9a3));
        prog.push_back(encode_addi(5'd3, 5'd0, 12'h07c));
        prog.push_back({7'd0, 5'd1, 5'd2, 3'b010, 5'd4, 7'b0100011});
        prog.push_back({12'h123, 5'd1, 3'b101, 5'd2, 7'b0010011});
        prog.push_back({7'd0, 5'd1, 5'd1, 3'b011, 5'd3, 7'b0110011});
        prog.push_back({7'b0100000, 5'd1, 5'd1, 3'b000, 5'd3, 7'b0110011});
        prog.push_back(encode_add(5'd4, 5'd2, 5'd3));
        prog.push_back(32'h0010_0073);
        run_program(1);
    endtask

    task automatic test_ebreak();
        prog.delete();
        prog.push_back(encode_addi(5'd1, 5'd0, 12'h011));
        prog.push_back(encode_addi(5'd2, 5'd1, 12'hfff));
        prog.push_back(32'h0010_0073);
        // Never reached while halted
        prog.push_back(encode_addi(5'd3, 5'd0, 12'h7ff));
        run_program(10);
    endtask

    initial begin
        seed_dummy = $urandom(32'hca91_4dc5);
        rst_n      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end

        test_addi_chain();
        test_auipc();
        test_add_two_sources();
        test_unknown_encodings();
        test_ebreak();

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/ifu.sv
hdl/idu.sv
hdl/regfile.sv
hdl/exu.sv
hdl/cpu_top.sv
bench/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator and run; exit status is the simulation result

cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
    -f project.f \
    --top-module cpu_tb \
    -o cpu_tb_sim &&
./obj_dir/cpu_tb_sim &&
echo "simulation exited cleanly" ||
{ echo "simulation or build reported an error"; exit 1; }
